//--- stcDemodTop.f
+incdir+include
design/stcDemodPkg.sv
design/regBusIf.sv
design/busDecoder.sv
design/topRegs.sv
design/adcCapture.sv
design/dacChannel.sv
design/stcDemodTop.sv
tests/stcDemodChecker.sv
tests/stcDemodTop_tb.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, then look for the pass line in the log
cd "$(dirname "$0")" &&
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert -f stcDemodTop.f --top-module stcDemodTop_tb &&
./obj_dir/VstcDemodTop_tb 2>&1 | tee sim.log
grep -qx "Test passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- tests/stcDemodTop_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "stcDemod_macros.svh"

module stcDemodTop_tb;

    localparam logic [1:0] opWrite    = 2'd0;
    localparam logic [1:0] opRead     = 2'd1;
    localparam logic [1:0] opStream   = 2'd2;   // Random ADC and STC samples
    localparam logic [1:0] opOverflow = 2'd3;   // Hold adc, raise adcOverflow

    typedef struct packed {
        logic [1:0]  kind;
        logic [12:0] addr;
        logic [3:0]  strb;
        logic [31:0] data;
        logic [31:0] expWord;
        logic [15:0] cycles;
    } stepT;

    stepT                 steps [$];
    logic                 clk, arstN, cs, adcOverflow, stcSampleEn, chkRd;
    logic                 dac0DataEn, dac1DataEn;
    stcDemodPkg::byteEnT  wrEn;
    stcDemodPkg::busAddrT addr;
    stcDemodPkg::busDataT dataIn, dataOut, expRd;
    stcDemodPkg::adcWordT adc;
    stcDemodPkg::sampleT  stcSample;
    stcDemodPkg::dacWordT dac0Data, dac1Data;
    stcDemodPkg::vidSelT  video0InSelect, video0OutSelect, video1InSelect, video1OutSelect;
    int                   readErrors, outErrors, totalErrors;
    int                   timeoutLimit = 0;
    int                   cycleCount = 0;

    stcDemodTop stcDemodTop_i (.*);
    stcDemodChecker stcDemodChecker_i (.*);

    always #5 clk = ~clk;

    task automatic addStep(input logic [1:0] kind, input logic [12:0] a, input logic [3:0] s,
                           input logic [31:0] d, input logic [31:0] e, input logic [15:0] n);
        steps.push_back(stepT'({kind, a, s, d, e, n}));
    endtask

    task automatic writeReg(input logic [12:0] a, input logic [3:0] s, input logic [31:0] d);
        addStep(opWrite, a, s, d, 32'h0, 16'd1);
    endtask

    task automatic readExpect(input logic [12:0] a, input logic [31:0] e);
        addStep(opRead, a, 4'h0, 32'h0, e, 16'd1);
    endtask

    // ****************************************
    // Stimulus table
    // ****************************************
    task automatic buildTable();
        readExpect(13'h000, {`FPGA_TYPE, 16'd601});
        readExpect(13'h1f00, 32'h0);                // Unmapped space
        readExpect(13'h00c, 32'h0);
        writeReg(13'h004, 4'hf, 32'h11223344);
        readExpect(13'h004, 32'h11223344);
        writeReg(13'h004, 4'h1, 32'haaaaaaaa);
        readExpect(13'h004, 32'h112233aa);
        writeReg(13'h004, 4'h4, 32'h55555555);
        writeReg(13'h004, 4'h8, 32'hcc000000);
        readExpect(13'h004, 32'hcc5533aa);
        writeReg(13'h004, 4'h2, 32'h0000ee00);
        readExpect(13'h004, 32'hcc55eeaa);
        for (int i = 0; i < 4; i++) begin           // Every code on both video channels
            writeReg(13'h008, 4'h1, {28'h0, 2'(i + 1), 2'(i)});
            readExpect(13'h008, {28'h0, 2'(i + 1), 2'(i)});
        end
        readExpect(13'h200, 32'h0);
        readExpect(13'h300, 32'h0);
        addStep(opStream, 13'h0, 4'h0, 32'h0, 32'h0, 16'd40);
        writeReg(13'h200, 4'h1, 32'h1);             // DAC0 from STC
        writeReg(13'h300, 4'h1, 32'h2);             // DAC1 from test value
        writeReg(13'h304, 4'h7, 32'h0002468a);
        readExpect(13'h304, 32'h0002468a);
        addStep(opStream, 13'h0, 4'h0, 32'h0, 32'h0, 16'd40);
        writeReg(13'h204, 4'hf, 32'hfff3ffff);
        readExpect(13'h204, 32'h0003ffff);
        writeReg(13'h200, 4'h1, 32'h2);
        writeReg(13'h300, 4'h1, 32'h3);             // Code 3 acts as test
        readExpect(13'h300, 32'h3);
        addStep(opStream, 13'h0, 4'h0, 32'h0, 32'h0, 16'd20);
        writeReg(13'h300, 4'h1, 32'h1);
        writeReg(13'h200, 4'h1, 32'h0);
        addStep(opStream, 13'h0, 4'h0, 32'h0, 32'h0, 16'd30);
        addStep(opOverflow, 13'h0, 4'h0, 32'h2abc, 32'h0, 16'd7);
        readExpect(13'h100, 32'd7);
        readExpect(13'h104, 32'h0000abc0);
        writeReg(13'h100, 4'h1, 32'h0);             // Clear counter
        readExpect(13'h100, 32'h0);
        addStep(opOverflow, 13'h0, 4'h0, 32'h0123, 32'h0, 16'd3);
        readExpect(13'h100, 32'd3);
        readExpect(13'h104, 32'hfffe1230);          // Negative sample sign extended
    endtask

    task automatic applyStep(input stepT st);
        logic [31:0] rnd;
        repeat (st.cycles) begin
            @(posedge clk);
            cs          <= (st.kind == opWrite) || (st.kind == opRead);
            wrEn        <= (st.kind == opWrite) ? st.strb : 4'h0;
            addr        <= st.addr;
            dataIn      <= st.data;
            expRd       <= st.expWord;
            chkRd       <= (st.kind == opRead);
            adcOverflow <= (st.kind == opOverflow);
            if (st.kind == opOverflow) begin
                adc <= st.data[13:0];
            end else if (st.kind == opStream) begin
                rnd = $urandom();
                adc <= rnd[13:0];
                rnd = $urandom();
                stcSample   <= rnd[17:0];
                stcSampleEn <= rnd[31];
            end
        end
    endtask

    initial begin
        clk         = 1'b0;
        arstN       = 1'b0;
        cs          = 1'b0;
        wrEn        = '0;
        addr        = '0;
        dataIn      = '0;
        adc         = '0;
        adcOverflow = 1'b0;
        stcSample   = '0;
        stcSampleEn = 1'b0;
        expRd       = '0;
        chkRd       = 1'b0;
        void'($urandom(32'hdeb30498));
        buildTable();
        timeoutLimit = 200;
        foreach (steps[i]) timeoutLimit += int'(steps[i].cycles);

        repeat (5) @(posedge clk);
        arstN <= 1'b1;
        foreach (steps[i]) applyStep(steps[i]);
        @(posedge clk);
        cs          <= 1'b0;
        wrEn        <= '0;
        chkRd       <= 1'b0;
        adcOverflow <= 1'b0;
        repeat (4) @(posedge clk);

        totalErrors = readErrors + outErrors;
        $display("Checks done: %0d read errors, %0d output errors, %0d total",
                 readErrors, outErrors, totalErrors);
        if (totalErrors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        @(posedge clk);
        while (cycleCount < timeoutLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout: run did not finish within %0d cycles", timeoutLimit);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/stcDemodChecker.sv
`timescale 1ns/10ps
`default_nettype none

`include "stcDemod_macros.svh"

module stcDemodChecker (
    input  wire                       clk,
    input  wire                       arstN,
    input  wire                       cs,
    input  wire stcDemodPkg::byteEnT  wrEn,
    input  wire stcDemodPkg::busAddrT addr,
    input  wire stcDemodPkg::busDataT dataIn,
    input  wire stcDemodPkg::busDataT dataOut,
    input  wire stcDemodPkg::busDataT expRd,
    input  wire                       chkRd,
    input  wire stcDemodPkg::adcWordT adc,
    input  wire stcDemodPkg::sampleT  stcSample,
    input  wire                       stcSampleEn,
    input  wire stcDemodPkg::dacWordT dac0Data,
    input  wire                       dac0DataEn,
    input  wire stcDemodPkg::dacWordT dac1Data,
    input  wire                       dac1DataEn,
    input  wire stcDemodPkg::vidSelT  video0InSelect,
    input  wire stcDemodPkg::vidSelT  video0OutSelect,
    input  wire stcDemodPkg::vidSelT  video1InSelect,
    input  wire stcDemodPkg::vidSelT  video1OutSelect,
    output int                        readErrors,
    output int                        outErrors
);

    stcDemodPkg::adcWordT adcHist [0:3];        // Index 3 is four cycles back
    stcDemodPkg::sampleT  stcHist [0:1];
    logic                 stcEnHist [0:1];
    logic [1:0]           srcHist [0:1][0:1];
    stcDemodPkg::sampleT  testHist [0:1][0:1];
    logic [1:0]           srcCopy [0:1];        // Shadow of each DAC source register
    stcDemodPkg::sampleT  testCopy [0:1];
    stcDemodPkg::vidSelT  vidCopy [0:1];
    int                   sinceReset = 0;
    int                   readCount = 0;
    int                   outCount = 0;

    assign readErrors = readCount;
    assign outErrors  = outCount;

    // Offset binary out: flipped sign bit, then the top magnitude bits
    function automatic stcDemodPkg::dacWordT formatDac(input stcDemodPkg::sampleT s);
        formatDac = {~s[17], s[16:4]};
    endfunction

    task automatic checkChannel(input int n, input stcDemodPkg::dacWordT data, input logic en);
        stcDemodPkg::dacWordT expData;
        logic                 expEn;
        case (srcHist[n][1])
            2'd0: begin
                expData = adcHist[3];           // Widen and narrow is lossless
                expEn   = 1'b1;
            end
            2'd1: begin
                expData = formatDac(stcHist[1]);
                expEn   = stcEnHist[1];
            end
            default: begin
                expData = formatDac(testHist[n][1]);
                expEn   = 1'b1;
            end
        endcase
        if (en !== expEn) begin
            $display("FAILED dac%0dDataEn: got %h expected %h", n, en, expEn);
            outCount++;
        end
        if ((sinceReset >= 4) && (data !== expData)) begin
            $display("FAILED dac%0dData: got %h expected %h", n, data, expData);
            outCount++;
        end
    endtask

    task automatic checkVideo(input int n, input stcDemodPkg::vidSelT inSel,
                              input stcDemodPkg::vidSelT outSel);
        if ((inSel !== vidCopy[n]) || (outSel !== {vidCopy[n][0], vidCopy[n][1]})) begin
            $display("FAILED video%0dInSelect/OutSelect: got %h/%h expected %h/%h",
                     n, inSel, outSel, vidCopy[n], {vidCopy[n][0], vidCopy[n][1]});
            outCount++;
        end
    endtask

    // A bus write lands at the next edge, so the shadows move after the checks
    task automatic snoopWrite();
        logic [4:0] space;
        int         n;
        space = addr[12:8];
        n     = (space == `SPACE_DAC1) ? 1 : 0;
        if ((space == `SPACE_DAC0) || (space == `SPACE_DAC1)) begin
            if ((addr[3:2] == 2'd0) && wrEn[0]) srcCopy[n] = dataIn[1:0];
            if (addr[3:2] == 2'd1) begin
                if (wrEn[0]) testCopy[n][7:0] = dataIn[7:0];
                if (wrEn[1]) testCopy[n][15:8] = dataIn[15:8];
                if (wrEn[2]) testCopy[n][17:16] = dataIn[17:16];
            end
        end
        if ((space == `SPACE_TOP) && (addr[3:2] == 2'd2) && wrEn[0]) begin
            vidCopy[0] = dataIn[1:0];
            vidCopy[1] = dataIn[3:2];
        end
    endtask

    // ****************************************
    // Compare on the falling edge
    // ****************************************
    always @(negedge clk) begin
        if (chkRd && (dataOut !== expRd)) begin
            $display("FAILED dataOut at addr %h: got %h expected %h", addr, dataOut, expRd);
            readCount++;
        end
        if (!arstN) begin
            if ((dac0DataEn !== 1'b0) || (dac1DataEn !== 1'b0)) begin
                $display("FAILED dacDataEn in reset: got %h/%h expected 0/0",
                         dac0DataEn, dac1DataEn);
                outCount++;
            end
            sinceReset = 0;
            for (int n = 0; n < 2; n++) begin
                srcCopy[n]  = 2'd0;             // Zero source means ADC
                testCopy[n] = '0;
                vidCopy[n]  = '0;
            end
        end else begin
            if (sinceReset >= 2) begin          // Enable pipe is two deep
                checkChannel(0, dac0Data, dac0DataEn);
                checkChannel(1, dac1Data, dac1DataEn);
            end
            if (sinceReset < 1000) sinceReset++;
        end
        checkVideo(0, video0InSelect, video0OutSelect);
        checkVideo(1, video1InSelect, video1OutSelect);

        for (int i = 3; i > 0; i--) adcHist[i] = adcHist[i-1];
        adcHist[0]   = adc;
        stcHist[1]   = stcHist[0];
        stcHist[0]   = stcSample;
        stcEnHist[1] = stcEnHist[0];
        stcEnHist[0] = stcSampleEn;
        for (int n = 0; n < 2; n++) begin
            srcHist[n][1]  = srcHist[n][0];
            srcHist[n][0]  = srcCopy[n];
            testHist[n][1] = testHist[n][0];
            testHist[n][0] = testCopy[n];
        end
        if (arstN && cs) snoopWrite();
    end

endmodule

`default_nettype wire

//--- design/stcDemodTop.sv
`timescale 1ns/10ps
`default_nettype none

module stcDemodTop (
    input  wire                     clk,
    input  wire                     arstN,
    input  wire                     cs,
    input  wire stcDemodPkg::byteEnT wrEn,
    input  wire stcDemodPkg::busAddrT addr,
    input  wire stcDemodPkg::busDataT dataIn,
    output stcDemodPkg::busDataT    dataOut,
    input  wire stcDemodPkg::adcWordT adc,
    input  wire                     adcOverflow,
    input  wire stcDemodPkg::sampleT stcSample,
    input  wire                     stcSampleEn,
    output stcDemodPkg::dacWordT    dac0Data,
    output logic                    dac0DataEn,
    output stcDemodPkg::dacWordT    dac1Data,
    output logic                    dac1DataEn,
    output stcDemodPkg::vidSelT     video0InSelect,
    output stcDemodPkg::vidSelT     video0OutSelect,
    output stcDemodPkg::vidSelT     video1InSelect,
    output stcDemodPkg::vidSelT     video1OutSelect
);

    stcDemodPkg::busDataT   topRd, adcRd, dac0Rd, dac1Rd;
    stcDemodPkg::sampleT    adcSample;
    logic                   topSel, adcSel, dac0Sel, dac1Sel;

    // ****************************************
    // Register bus
    // ****************************************
    regBusIf bus ();

    assign bus.cs     = cs;
    assign bus.wrEn   = wrEn;
    assign bus.addr   = addr;
    assign bus.wrData = dataIn;

    busDecoder busDecoder_i (
        .bus(bus), .topSel(topSel), .adcSel(adcSel), .dac0Sel(dac0Sel), .dac1Sel(dac1Sel),
        .topRd(topRd), .adcRd(adcRd), .dac0Rd(dac0Rd), .dac1Rd(dac1Rd), .dataOut(dataOut)
    );

    // ****************************************
    // Peers
    // ****************************************
    topRegs topRegs_i (
        .clk(clk), .arstN(arstN), .bus(bus), .sel(topSel), .rdData(topRd),
        .video0InSelect(video0InSelect), .video0OutSelect(video0OutSelect),
        .video1InSelect(video1InSelect), .video1OutSelect(video1OutSelect)
    );

    adcCapture adcCapture_i (
        .clk(clk), .arstN(arstN), .bus(bus), .sel(adcSel), .rdData(adcRd),
        .adc(adc), .adcOverflow(adcOverflow), .adcSample(adcSample)
    );

    dacChannel dac0 (
        .clk(clk), .arstN(arstN), .bus(bus), .sel(dac0Sel), .rdData(dac0Rd),
        .adcSample(adcSample), .stcSample(stcSample), .stcSampleEn(stcSampleEn),
        .dacData(dac0Data), .dacDataEn(dac0DataEn)
    );

    dacChannel dac1 (
        .clk(clk), .arstN(arstN), .bus(bus), .sel(dac1Sel), .rdData(dac1Rd),
        .adcSample(adcSample), .stcSample(stcSample), .stcSampleEn(stcSampleEn),
        .dacData(dac1Data), .dacDataEn(dac1DataEn)
    );

endmodule

`default_nettype wire

//--- design/dacChannel.sv
`timescale 1ns/10ps
`default_nettype none

`include "stcDemod_macros.svh"

module dacChannel (
    input  wire                     clk,
    input  wire                     arstN,
    regBusIf.peer                   bus,
    input  wire                     sel,
    output stcDemodPkg::busDataT    rdData,
    input  wire stcDemodPkg::sampleT adcSample,
    input  wire stcDemodPkg::sampleT stcSample,
    input  wire                     stcSampleEn,
    output stcDemodPkg::dacWordT    dacData,
    output logic                    dacDataEn
);

    stcDemodPkg::dacSourceT srcReg;
    stcDemodPkg::sampleT    testVal;
    stcDemodPkg::sampleT    muxSample;
    logic                   muxEn;
    logic [3:0]             offset;

    assign offset = {bus.addr[3:2], 2'b00};

    // ****************************************
    // Source and test value registers
    // ****************************************
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            srcReg  <= stcDemodPkg::srcAdc;
            testVal <= '0;
        end else if (sel) begin
            if ((offset == `REG_OFS0) && bus.wrEn[0]) begin
                srcReg <= stcDemodPkg::dacSourceT'(bus.wrData[1:0]);
            end
            if (offset == `REG_OFS1) begin
                if (bus.wrEn[0]) testVal[7:0]   <= bus.wrData[7:0];
                if (bus.wrEn[1]) testVal[15:8]  <= bus.wrData[15:8];
                if (bus.wrEn[2]) testVal[17:16] <= bus.wrData[17:16];
            end
        end
    end

    always_comb begin
        case (offset)
            `REG_OFS0: rdData = {30'h0, srcReg};
            `REG_OFS1: rdData = {14'h0, testVal};
            default:   rdData = '0;
        endcase
    end

    // ****************************************
    // Source mux and DAC formatter
    // ****************************************
    always_ff @(posedge clk) begin
        case (srcReg)
            stcDemodPkg::srcAdc: muxSample <= adcSample;
            stcDemodPkg::srcStc: muxSample <= stcSample;
            default:             muxSample <= testVal;     // Test and code 3
        endcase
        dacData <= {~muxSample[`SAMPLE_BITS-1], muxSample[`SAMPLE_BITS-2:4]};
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            muxEn     <= 1'b0;
            dacDataEn <= 1'b0;
        end else begin
            muxEn     <= (srcReg == stcDemodPkg::srcStc) ? stcSampleEn : 1'b1;
            dacDataEn <= muxEn;             // Keeps strobe aligned with data
        end
    end

    // Enable must stay defined even while the STC stream is idle
    assert property (@(posedge clk) disable iff (!arstN) !$isunknown(dacDataEn))
        else $error("dacChannel: dacDataEn unknown");

endmodule

`default_nettype wire

//--- design/adcCapture.sv
`timescale 1ns/10ps
`default_nettype none

`include "stcDemod_macros.svh"

module adcCapture (
    input  wire                     clk,
    input  wire                     arstN,
    regBusIf.peer                   bus,
    input  wire                     sel,
    output stcDemodPkg::busDataT    rdData,
    input  wire stcDemodPkg::adcWordT adc,
    input  wire                     adcOverflow,
    output stcDemodPkg::sampleT     adcSample
);

    stcDemodPkg::adcWordT   adcReg;
    logic [15:0]            ovfCount;
    logic                   ovfClear;
    logic [3:0]             offset;

    assign offset   = {bus.addr[3:2], 2'b00};
    assign ovfClear = sel && (offset == `REG_OFS0) && (|bus.wrEn);  // Any lane clears

    // ****************************************
    // Reclock and widen
    // ****************************************
    always_ff @(posedge clk) begin
        adcReg    <= adc;
        // Flip offset binary MSB, pad to sample width
        adcSample <= {~adcReg[`ADC_BITS-1], adcReg[`ADC_BITS-2:0],
                      {(`SAMPLE_BITS-`ADC_BITS){1'b0}}};
    end

    // Saturating overflow counter
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            ovfCount <= '0;
        end else if (ovfClear) begin
            ovfCount <= '0;
        end else if (adcOverflow && (ovfCount != 16'hffff)) begin
            ovfCount <= ovfCount + 16'd1;
        end
    end

    always_comb begin
        case (offset)
            `REG_OFS0: rdData = {16'h0, ovfCount};
            `REG_OFS1: rdData = {{(`BUS_DATA_BITS-`SAMPLE_BITS){adcSample[`SAMPLE_BITS-1]}},
                                 adcSample};
            default:   rdData = '0;
        endcase
    end

    // A full counter only returns to zero through a bus clear
    assert property (@(posedge clk) disable iff (!arstN)
        (ovfCount == 16'hffff) && !ovfClear |=> ovfCount != 16'h0)
        else $error("adcCapture: overflow counter wrapped");

endmodule

`default_nettype wire

//--- design/topRegs.sv
`timescale 1ns/10ps
`default_nettype none

`include "stcDemod_macros.svh"

module topRegs (
    input  wire                     clk,
    input  wire                     arstN,
    regBusIf.peer                   bus,
    input  wire                     sel,
    output stcDemodPkg::busDataT    rdData,
    output stcDemodPkg::vidSelT     video0InSelect,
    output stcDemodPkg::vidSelT     video0OutSelect,
    output stcDemodPkg::vidSelT     video1InSelect,
    output stcDemodPkg::vidSelT     video1OutSelect
);

    stcDemodPkg::busDataT   scratch;
    stcDemodPkg::vidSelT    vid0Sel;
    stcDemodPkg::vidSelT    vid1Sel;
    logic [3:0]             offset;

    assign offset = {bus.addr[3:2], 2'b00};

    // ****************************************
    // Register writes
    // ****************************************
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            scratch <= '0;
            vid0Sel <= '0;
            vid1Sel <= '0;
        end else if (sel) begin
            if (offset == `REG_OFS1) begin
                for (int i = 0; i < 4; i++) begin
                    if (bus.wrEn[i]) begin
                        scratch[8*i +: 8] <= bus.wrData[8*i +: 8];
                    end
                end
            end
            if ((offset == `REG_OFS2) && bus.wrEn[0]) begin
                vid0Sel <= bus.wrData[1:0];
                vid1Sel <= bus.wrData[3:2];
            end
        end
    end

    always_comb begin
        case (offset)
            `REG_OFS0: rdData = {`FPGA_TYPE, `VER_NUMBER};    // Read only
            `REG_OFS1: rdData = scratch;
            `REG_OFS2: rdData = {28'h0, vid1Sel, vid0Sel};
            default:   rdData = '0;
        endcase
    end

    // Board swaps the two out-select lines, so exchange them here
    assign video0InSelect  = vid0Sel;
    assign video0OutSelect = {vid0Sel[0], vid0Sel[1]};
    assign video1InSelect  = vid1Sel;
    assign video1OutSelect = {vid1Sel[0], vid1Sel[1]};

endmodule

`default_nettype wire

//--- design/busDecoder.sv
`timescale 1ns/10ps
`default_nettype none

`include "stcDemod_macros.svh"

module busDecoder (
    regBusIf.decoder                bus,
    output logic                    topSel,
    output logic                    adcSel,
    output logic                    dac0Sel,
    output logic                    dac1Sel,
    input  wire stcDemodPkg::busDataT topRd,
    input  wire stcDemodPkg::busDataT adcRd,
    input  wire stcDemodPkg::busDataT dac0Rd,
    input  wire stcDemodPkg::busDataT dac1Rd,
    output stcDemodPkg::busDataT    dataOut
);

    logic [4:0] space;

    assign space = bus.addr[`BUS_ADDR_BITS-1:8];    // Upper address picks the peer

    // ****************************************
    // Space decode
    // ****************************************
    always_comb begin
        topSel  = bus.cs && (space == `SPACE_TOP);
        adcSel  = bus.cs && (space == `SPACE_ADC);
        dac0Sel = bus.cs && (space == `SPACE_DAC0);
        dac1Sel = bus.cs && (space == `SPACE_DAC1);
    end

    // Read-back mux, unmapped spaces give zero
    always_comb begin
        if (topSel) begin
            dataOut = topRd;
        end else if (adcSel) begin
            dataOut = adcRd;
        end else if (dac0Sel) begin
            dataOut = dac0Rd;
        end else if (dac1Sel) begin
            dataOut = dac1Rd;
        end else begin
            dataOut = '0;
        end
    end

    // Peers rely on never seeing two selects at once
    always_comb begin
        assert ($onehot0({topSel, adcSel, dac0Sel, dac1Sel}))
            else $error("busDecoder: more than one peer selected");
    end

endmodule

`default_nettype wire

//--- design/regBusIf.sv
`timescale 1ns/10ps
`default_nettype none

interface regBusIf;

    logic                   cs;         // Host chip select
    stcDemodPkg::byteEnT    wrEn;       // Byte lane write strobes
    stcDemodPkg::busAddrT   addr;
    stcDemodPkg::busDataT   wrData;

    // Space decode needs only select and address
    modport decoder (
        input cs,
        input addr
    );

    // Peers get their own select from the decoder
    modport peer (
        input wrEn,
        input addr,
        input wrData
    );

endinterface

`default_nettype wire

//--- design/stcDemodPkg.sv
`default_nettype none

`include "stcDemod_macros.svh"

package stcDemodPkg;

    typedef logic [`BUS_ADDR_BITS-1:0]      busAddrT;   // Byte address
    typedef logic [`BUS_DATA_BITS-1:0]      busDataT;
    typedef logic [`BUS_DATA_BITS/8-1:0]    byteEnT;    // One strobe per byte lane

    typedef logic [`ADC_BITS-1:0]           adcWordT;   // Offset binary
    typedef logic signed [`SAMPLE_BITS-1:0] sampleT;    // Two's complement
    typedef logic [`ADC_BITS-1:0]           dacWordT;   // Offset binary
    typedef logic [1:0]                     vidSelT;

    // DAC source select, code 3 is not listed and acts as srcTest
    typedef enum logic [1:0] {
        srcAdc  = 2'd0,
        srcStc  = 2'd1,
        srcTest = 2'd2
    } dacSourceT;

endpackage

`default_nettype wire

//--- include/stcDemod_macros.svh
`ifndef STCDEMOD_MACROS_SVH
`define STCDEMOD_MACROS_SVH

// ****************************************
// Build identification
// ****************************************
`define VER_NUMBER      16'd601         // Low half of the version word
`define FPGA_TYPE       16'h6100        // Board code, high half

// ****************************************
// Datapath widths
// ****************************************
`define ADC_BITS        14
`define SAMPLE_BITS     18
`define BUS_ADDR_BITS   13
`define BUS_DATA_BITS   32

// Address bits 12 to 8 pick the peer
`define SPACE_TOP       5'd0
`define SPACE_ADC       5'd1
`define SPACE_DAC0      5'd2
`define SPACE_DAC1      5'd3

// Register offsets, only bits 3 to 2 are decoded
`define REG_OFS0        4'h0
`define REG_OFS1        4'h4
`define REG_OFS2        4'h8

`endif
